/* hdl/crc24_pkg.sv */
// CRC24 constants, input/evolved/history beat structs and the 64-bit CRC step function

`default_nettype none

package crc24_pkg;

    //////////////////////////////
    // constants
    //////////////////////////////

    // generator, msb first, no reflection
    localparam logic [23:0] crc24_poly = 24'h328b63;
    // every packet starts from all ones
    localparam logic [23:0] crc24_init = 24'hffffff;
    // data word width in bits
    localparam int          word_w     = 64;

    //////////////////////////////
    // beat types
    //////////////////////////////

    // one input word as it arrives
    typedef struct packed {
        logic              sop;
        logic [word_w-1:0] data;
    } in_beat_t;

    // one word after evaluation from a zero state
    typedef struct packed {
        logic        valid;
        logic        sop;
        logic [23:0] evo;
    } evo_beat_t;

    // packet history as seen by the current beat
    typedef struct packed {
        // earlier words of this packet, capped at 3
        logic [1:0]  covered;
        // evolved word n-1
        logic [23:0] evo_n1;
        // evolved word n-2
        logic [23:0] evo_n2;
        // full CRC up to and including word n-3
        logic [23:0] roll_n3;
    } hist_t;

    //////////////////////////////
    // step function
    //////////////////////////////

    // advance a state through one word, msb first
    // the map is affine, so step(s, d) = step(s, 0) ^ step(0, d)
    function automatic logic [23:0] crc24_step(
        input logic [23:0]       state,
        input logic [word_w-1:0] data
    );
        logic [23:0] s;
        logic        fb;
        s = state;
        for (int i = word_w - 1; i >= 0; i--) begin
            // feedback is the outgoing msb mixed with the data bit
            fb = s[23] ^ data[i];
            s  = {s[22:0], 1'b0};
            if (fb) begin
                s = s ^ crc24_poly;
            end
        end
        return s;
    endfunction

endpackage

`default_nettype wire

/* hdl/crc24_zero_adv.sv */
// combinational advance of a CRC24 state through a run of 64-bit zero words

`timescale 1ns/100ps
`default_nettype none

module crc24_zero_adv import crc24_pkg::*; #(
    // number of zero words to run through, 1 to 4
    parameter int steps = 1
) (
    input  wire logic [23:0] state,
    output logic      [23:0] adv
);

    //////////////////////////////
    // step chain
    //////////////////////////////

    // chain[0] is the input state, chain[k] has seen k zero words
    logic [23:0] chain [0:steps];

    assign chain[0] = state;

    // each stage is one crc24_step with zero data
    // with zero data only the state feedback taps remain,
    // so synthesis flattens this into a plain xor matrix
    for (genvar i = 0; i < steps; i++) begin : g_step
        assign chain[i+1] = crc24_step(chain[i], {word_w{1'b0}});
    end

    //////////////////////////////
    // result
    //////////////////////////////

    // last stage is the full advance
    assign adv = chain[steps];

    // a constant state input folds the whole chain into a constant,
    // which is how the combine stage gets the advanced init states

endmodule

`default_nettype wire

/* hdl/crc24_word_eval.sv */
// input register stage producing the zero-initialized CRC24 of each accepted word

`timescale 1ns/100ps
`default_nettype none

module crc24_word_eval import crc24_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst,
    input  wire logic      ena,
    input  wire logic      in_valid,
    input  wire in_beat_t  in_beat,
    output evo_beat_t      evo_beat
);

    //////////////////////////////
    // evaluation
    //////////////////////////////

    // a word only counts with the global enable high
    logic        accept;
    // CRC of the word alone from a zero state
    logic [23:0] evo_next;

    assign accept   = ena && in_valid;
    assign evo_next = crc24_step(24'h000000, in_beat.data);

    //////////////////////////////
    // output register
    //////////////////////////////

    logic        valid_q;
    logic        sop_q;
    logic [23:0] evo_q;

    // valid follows in_valid on every enabled edge
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= 1'b0;
        end else if (ena) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on an accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            sop_q <= in_beat.sop;
            evo_q <= evo_next;
        end
    end

    assign evo_beat = '{valid: valid_q, sop: sop_q, evo: evo_q};

endmodule

`default_nettype wire

/* hdl/crc24_history.sv */
// per-packet history of the two previous evolved words, the rolling older CRC and word count

`timescale 1ns/100ps
`default_nettype none

module crc24_history import crc24_pkg::*; #(
    // zero words per history slot
    parameter int steps = 1
) (
    input  wire logic      clk,
    input  wire logic      arst,
    input  wire logic      ena,
    input  wire evo_beat_t evo_beat,
    output evo_beat_t      cur_beat,
    output hist_t          hist
);

    //////////////////////////////
    // slot state
    //////////////////////////////

    // words seen so far in this packet, saturates at 3
    logic [1:0]  count_q;
    // evolved words n-1 and n-2
    logic [23:0] n1_q;
    logic [23:0] n2_q;
    // full CRC of everything older than n-2
    logic [23:0] roll_q;

    // one-slot advances feeding the rolling CRC
    logic [23:0] roll_adv;
    logic [23:0] init_adv;

    crc24_zero_adv #(.steps(steps)) u_roll_adv (
        .state (roll_q),
        .adv   (roll_adv)
    );

    // constant after synthesis
    crc24_zero_adv #(.steps(steps)) u_init_adv (
        .state (crc24_init),
        .adv   (init_adv)
    );

    //////////////////////////////
    // slot update
    //////////////////////////////

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            count_q <= 2'd0;
            n1_q    <= 24'h000000;
            n2_q    <= 24'h000000;
            roll_q  <= 24'h000000;
        end else if (ena && evo_beat.valid) begin
            if (evo_beat.sop) begin
                // new packet, only this word is history now
                count_q <= 2'd1;
                n1_q    <= evo_beat.evo;
                n2_q    <= 24'h000000;
                roll_q  <= 24'h000000;
            end else begin
                if (count_q != 2'd3) begin
                    count_q <= count_q + 2'd1;
                end
                n1_q <= evo_beat.evo;
                n2_q <= n1_q;
                // first word to leave n2 starts the roll from the init state
                if (count_q == 2'd2) begin
                    roll_q <= init_adv ^ n2_q;
                end else if (count_q == 2'd3) begin
                    roll_q <= roll_adv ^ n2_q;
                end
            end
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // sop hides all history from the beat that carries it
    assign hist = '{
        covered: evo_beat.sop ? 2'd0 : count_q,
        evo_n1:  n1_q,
        evo_n2:  n2_q,
        roll_n3: roll_q
    };

    assign cur_beat = evo_beat;

endmodule

`default_nettype wire

/* hdl/crc24_combine.sv */
// alignment and xor of evolved terms into the packet CRC, with a late init-state select

`timescale 1ns/100ps
`default_nettype none

module crc24_combine import crc24_pkg::*; #(
    // zero words per history slot
    parameter int steps = 1
) (
    input  wire logic        clk,
    input  wire logic        arst,
    input  wire logic        ena,
    input  wire evo_beat_t   cur_beat,
    input  wire hist_t       hist,
    output logic             crc_valid,
    output logic      [23:0] crc_out
);

    //////////////////////////////
    // advanced init states
    //////////////////////////////

    // all constants, one per possible packet length so far
    logic [23:0] init_adv1;
    logic [23:0] init_adv2;
    logic [23:0] init_adv3;
    logic [23:0] init_adv4;

    crc24_zero_adv #(.steps(steps))     u_init_adv1 (.state(crc24_init), .adv(init_adv1));
    crc24_zero_adv #(.steps(2 * steps)) u_init_adv2 (.state(crc24_init), .adv(init_adv2));
    crc24_zero_adv #(.steps(3 * steps)) u_init_adv3 (.state(crc24_init), .adv(init_adv3));
    crc24_zero_adv #(.steps(4 * steps)) u_init_adv4 (.state(crc24_init), .adv(init_adv4));

    //////////////////////////////
    // advanced history terms
    //////////////////////////////

    // bring each older word up to the current position
    logic [23:0] n1_adv;
    logic [23:0] n2_adv;
    logic [23:0] roll_adv;

    crc24_zero_adv #(.steps(steps))     u_n1_adv   (.state(hist.evo_n1),  .adv(n1_adv));
    crc24_zero_adv #(.steps(2 * steps)) u_n2_adv   (.state(hist.evo_n2),  .adv(n2_adv));
    crc24_zero_adv #(.steps(3 * steps)) u_roll_adv (.state(hist.roll_n3), .adv(roll_adv));

    //////////////////////////////
    // first stage registers
    //////////////////////////////

    // control, delayed one cycle
    logic        valid_d;
    logic [1:0]  covered_d;
    // gated partial terms
    logic [23:0] n1_term;
    logic [23:0] n2_term;
    logic [23:0] old_term;
    // current word, latency matched
    logic [23:0] evo_r;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_d   <= 1'b0;
            covered_d <= 2'd0;
        end else if (ena) begin
            valid_d   <= cur_beat.valid;
            covered_d <= hist.covered;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            // n-1 counts once the packet has any earlier word
            n1_term <= (hist.covered != 2'd0) ? n1_adv : 24'h000000;
            // n-2 needs at least two earlier words
            n2_term <= (hist.covered >= 2'd2) ? n2_adv : 24'h000000;
            // roll_n3 already carries the init state
            // strip the four-slot init so the late select is the same for every count
            old_term <= (hist.covered == 2'd3) ? (roll_adv ^ init_adv4) : 24'h000000;
            evo_r    <= cur_beat.evo;
        end
    end

    //////////////////////////////
    // late init select
    //////////////////////////////

    // picked after the register from the delayed count
    logic [23:0] init_term;

    always_comb begin
        case (covered_d)
            2'd0:    init_term = init_adv1;
            2'd1:    init_term = init_adv2;
            2'd2:    init_term = init_adv3;
            default: init_term = init_adv4;
        endcase
    end

    //////////////////////////////
    // output stage
    //////////////////////////////

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            crc_valid <= 1'b0;
            crc_out   <= crc24_init;
        end else if (ena) begin
            crc_valid <= valid_d;
            // holds between words
            if (valid_d) begin
                crc_out <= evo_r ^ init_term ^ n1_term ^ n2_term ^ old_term;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/crc24_burst_top.sv */
// top level wiring word evaluation, packet history and CRC combine

`timescale 1ns/100ps
`default_nettype none

module crc24_burst_top import crc24_pkg::*; (
    input  wire logic        clk,
    input  wire logic        arst,
    input  wire logic        ena,
    input  wire logic        in_valid,
    input  wire in_beat_t    in_beat,
    output logic             crc_valid,
    output logic      [23:0] crc_out
);

    //////////////////////////////
    // internal beats
    //////////////////////////////

    // registered evolved word
    evo_beat_t evo_beat;
    // same beat, seen alongside its history
    evo_beat_t cur_beat;
    // packet state before the current beat
    hist_t     hist;

    //////////////////////////////
    // pipeline
    //////////////////////////////

    // stage 1, CRC of each word alone
    crc24_word_eval u_word_eval (
        .clk      (clk),
        .arst     (arst),
        .ena      (ena),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .evo_beat (evo_beat)
    );

    // one 64-bit zero word per history slot
    crc24_history #(.steps(1)) u_history (
        .clk      (clk),
        .arst     (arst),
        .ena      (ena),
        .evo_beat (evo_beat),
        .cur_beat (cur_beat),
        .hist     (hist)
    );

    // stages 2 and 3, align and fold
    crc24_combine #(.steps(1)) u_combine (
        .clk       (clk),
        .arst      (arst),
        .ena       (ena),
        .cur_beat  (cur_beat),
        .hist      (hist),
        .crc_valid (crc_valid),
        .crc_out   (crc_out)
    );

endmodule

`default_nettype wire

/* tb/crc24_burst_chk.sv */
// concurrent assertions on the combine stage outputs, bound into crc24_combine

`timescale 1ns/100ps
`default_nettype none

module crc24_burst_chk import crc24_pkg::*; (
    input wire logic        clk,
    input wire logic        arst,
    input wire logic        ena,
    input wire evo_beat_t   cur_beat,
    input wire logic        crc_valid,
    input wire logic [23:0] crc_out
);

    //////////////////////////////
    // valid tracking
    //////////////////////////////

    // cur_beat already trails the accepted word by one enabled cycle
    // so two more enabled edges make three in total
    logic [1:0] vpipe;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            vpipe <= 2'b00;
        end else if (ena) begin
            vpipe <= {vpipe[0], cur_beat.valid};
        end
    end

    //////////////////////////////
    // assertions
    //////////////////////////////

    a_quiet_in_reset: assert property (@(posedge clk) arst |-> !crc_valid)
        else $error("crc_valid high during reset");

    a_latency: assert property (@(posedge clk) disable iff (arst) crc_valid == vpipe[1])
        else $error("crc_valid not three enabled cycles after the accepted word");

    a_known_out: assert property (@(posedge clk) disable iff (arst)
        crc_valid |-> !$isunknown(crc_out))
        else $error("crc_out has unknown bits while valid");

endmodule

bind crc24_combine crc24_burst_chk u_chk (
    .clk       (clk),
    .arst      (arst),
    .ena       (ena),
    .cur_beat  (cur_beat),
    .crc_valid (crc_valid),
    .crc_out   (crc_out)
);

`default_nettype wire

/* tb/crc24_burst_tb.sv */
// testbench for crc24_burst_top with directed tests, bit-serial reference model and watchdog

`timescale 1ns/100ps
`default_nettype none

module crc24_burst_tb import crc24_pkg::*; ();

    //////////////////////////////
    // constants
    //////////////////////////////

    localparam logic [23:0] ref_poly    = 24'h328b63;
    localparam logic [23:0] ref_init    = 24'hffffff;
    localparam logic [31:0] seed        = 32'h55aa1ac4;
    // upper bound on words sent over all tests
    localparam int          total_words = 120;
    // ten cycles per word plus room for reset and drains
    localparam int          limit_ns    = (total_words * 10 + 300) * 10;

    logic        clk = 1'b0;
    logic        arst;
    logic        ena;
    logic        in_valid;
    in_beat_t    in_beat;
    logic        crc_valid;
    logic [23:0] crc_out;

    // expected CRCs in output order
    logic [23:0] exp_q [$];
    // CRC of the packet so far, as the reference sees it
    logic [23:0] model_crc;
    logic [31:0] rng;
    logic        stall_mode;
    logic        edge_en = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;

    crc24_burst_top DUT (
        .clk       (clk),
        .arst      (arst),
        .ena       (ena),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .crc_valid (crc_valid),
        .crc_out   (crc_out)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // reference and helpers
    //////////////////////////////

    // one bit at a time, msb first, no reflection
    function automatic logic [23:0] ref_crc_word(input logic [23:0] crc, input logic [63:0] d);
        logic [23:0] c;
        logic        fb;
        c = crc;
        for (int i = 63; i >= 0; i--) begin
            fb = c[23] ^ d[i];
            c  = c << 1;
            if (fb) begin
                c = c ^ ref_poly;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %0s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // drive tasks
    //////////////////////////////

    // random ena low in stall mode, roughly one cycle in four
    task automatic pick_ena();
        ena = stall_mode ? ((next_rand() & 32'h3) != 0) : 1'b1;
    endtask

    // hold the word until an enabled edge takes it
    task automatic send_word(input logic sop, input logic [63:0] data);
        logic taken;
        if (sop) begin
            model_crc = ref_init;
        end
        model_crc = ref_crc_word(model_crc, data);
        exp_q.push_back(model_crc);
        in_valid = 1'b1;
        in_beat  = '{sop: sop, data: data};
        do begin
            pick_ena();
            taken = ena;
            @(posedge clk);
            #1;
        end while (!taken);
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        in_beat  = '0;
        repeat (n) begin
            pick_ena();
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_packet(input int len, input logic gaps);
        for (int i = 0; i < len; i++) begin
            send_word(i == 0, {next_rand(), next_rand()});
            if (gaps && (next_rand() % 4 == 0)) begin
                idle(1 + next_rand() % 3);
            end
        end
    endtask

    // wait for every outstanding result, then a few idle cycles for strays
    task automatic drain(input string name, input int err_start);
        int waited;
        waited     = 0;
        stall_mode = 1'b0;
        ena        = 1'b1;
        in_valid   = 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("error at %0t: %0d results never came out", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        tests++;
        $display("test %0s finished with %0d errors", name, errors - err_start);
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    // a new result exists only after an enabled edge
    always @(posedge clk) begin
        edge_en = ena;
    end

    always @(negedge clk) begin
        if (!arst && edge_en && crc_valid) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: crc_valid with no word outstanding", $time);
                errors++;
            end else begin
                check_val("crc_out", crc_out, exp_q.pop_front());
            end
        end
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int e;
        arst       = 1'b1;
        ena        = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        rng        = seed;
        model_crc  = ref_init;
        stall_mode = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst = 1'b0;
        ena  = 1'b1;

        // reset state, nothing comes out before the first word
        e = errors;
        repeat (6) begin
            check_val("crc_valid", crc_valid, 1'b0);
            check_val("crc_out", crc_out, ref_init);
            @(posedge clk);
            #1;
        end
        drain("reset", e);

        // covered stays 0
        e = errors;
        for (int i = 0; i < 8; i++) begin
            send_packet(1, 1'b0);
        end
        drain("single_word", e);

        // covered 1 to 3
        e = errors;
        send_packet(2, 1'b0);
        send_packet(3, 1'b0);
        send_packet(4, 1'b0);
        drain("short_packets", e);

        // rolling term over long packets
        e = errors;
        send_packet(10, 1'b0);
        send_packet(17, 1'b0);
        drain("long_packets", e);

        // ena stalls and input gaps mid-packet
        e = errors;
        stall_mode = 1'b1;
        send_packet(5, 1'b1);
        send_packet(1, 1'b1);
        send_packet(12, 1'b1);
        send_packet(3, 1'b1);
        drain("stalls", e);

        // sop right after a long packet restarts from all ones
        e = errors;
        send_packet(17, 1'b0);
        send_packet(3, 1'b0);
        send_packet(1, 1'b0);
        send_packet(9, 1'b0);
        drain("back_to_back", e);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* crc24_burst_top.f */
hdl/crc24_pkg.sv
hdl/crc24_zero_adv.sv
hdl/crc24_word_eval.sv
hdl/crc24_history.sv
hdl/crc24_combine.sv
hdl/crc24_burst_top.sv
tb/crc24_burst_chk.sv
tb/crc24_burst_tb.sv
